//--- src/pwm_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared modulus, widths, latencies, share and randomness types and the
// lazy three-operand modular adder used by the masked datapath
////////////////////////////////////////////////////////////////////////////
package pwm_pkg;

    // ML-DSA coefficients live in Z_q with q = 2^23 - 2^13 + 1
    localparam int COEFF_W = 23;
    localparam int PROD_W = 2 * COEFF_W;
    localparam logic [COEFF_W-1:0] Q = 23'd8380417;

    // twice the modulus, sized for the widened three-operand sum
    localparam logic [COEFF_W+1:0] Q_X2 = {1'b0, Q, 1'b0};

    // the multiplier has three register stages and the adder adds one more
    localparam int MULT_LATENCY = 3;
    localparam int PWM_LATENCY = MULT_LATENCY + 1;

    // one coefficient split into two arithmetic shares, sum mod q is the value
    typedef struct packed {
        logic [COEFF_W-1:0] share0;
        logic [COEFF_W-1:0] share1;
    } masked_coeff_t;

    // fresh masks for the product and for the final sum, both below q
    typedef struct packed {
        logic [COEFF_W-1:0] rnd_mult;
        logic [COEFF_W-1:0] rnd_add;
    } pwm_rnd_t;

    // returns (a + b + c) mod q
    // a and b must be below q, c may be as large as q itself so that a
    // negated mask q - r can be passed in without its own reduction
    function automatic logic [COEFF_W-1:0] mod_add3(input logic [COEFF_W-1:0] a,
                                                    input logic [COEFF_W-1:0] b,
                                                    input logic [COEFF_W-1:0] c);
        logic [COEFF_W+1:0] s;
        s = {2'b00, a} + {2'b00, b} + {2'b00, c};
        // the raw sum stays below 3q, so at most two subtractions are needed
        if (s >= Q_X2) begin
            s = s - Q_X2;
        end else if (s >= {2'b00, Q}) begin
            s = s - {2'b00, Q};
        end
        return s[COEFF_W-1:0];
    endfunction

endpackage

//--- src/masked_mod_mult.sv
////////////////////////////////////////////////////////////////////////////
// three-stage masked modular multiplier for two-share operands
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module masked_mod_mult
    import pwm_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               zeroize,
    input  masked_coeff_t      u,
    input  masked_coeff_t      v,
    input  logic [COEFF_W-1:0] rnd,
    output masked_coeff_t      prod
);

    // stage 1 holds the four raw cross products of the shares
    logic [PROD_W-1:0] p00_q;
    logic [PROD_W-1:0] p01_q;
    logic [PROD_W-1:0] p10_q;
    logic [PROD_W-1:0] p11_q;

    // stage 2 holds each cross product reduced below q
    logic [COEFF_W-1:0] r00_q;
    logic [COEFF_W-1:0] r01_q;
    logic [COEFF_W-1:0] r10_q;
    logic [COEFF_W-1:0] r11_q;

    // the mask rides along with its item until it is consumed at stage 3
    logic [COEFF_W-1:0] rnd_s1;
    logic [COEFF_W-1:0] rnd_s2;

    // q - r is at most q, which the lazy adder accepts as its third operand
    logic [COEFF_W-1:0] rnd_neg;

    assign rnd_neg = Q - rnd_s2;

    always_ff @(posedge clk) begin
        // a wipe must also drop every partial product of the shares
        if (reset || zeroize) begin
            p00_q  <= '0;
            p01_q  <= '0;
            p10_q  <= '0;
            p11_q  <= '0;
            rnd_s1 <= '0;
        end else begin
            // share0 of u only ever meets v, never u.share1, so no clear value forms
            p00_q  <= PROD_W'(u.share0) * PROD_W'(v.share0);
            p01_q  <= PROD_W'(u.share0) * PROD_W'(v.share1);
            p10_q  <= PROD_W'(u.share1) * PROD_W'(v.share0);
            p11_q  <= PROD_W'(u.share1) * PROD_W'(v.share1);
            rnd_s1 <= rnd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            r00_q  <= '0;
            r01_q  <= '0;
            r10_q  <= '0;
            r11_q  <= '0;
            rnd_s2 <= '0;
        end else begin
            // each product is below q^2, the remainder fits one coefficient
            r00_q  <= COEFF_W'(p00_q % PROD_W'(Q));
            r01_q  <= COEFF_W'(p01_q % PROD_W'(Q));
            r10_q  <= COEFF_W'(p10_q % PROD_W'(Q));
            r11_q  <= COEFF_W'(p11_q % PROD_W'(Q));
            rnd_s2 <= rnd_s1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            prod <= '0;
        end else begin
            // the mask is added to one share and taken from the other,
            // so the sum of the output shares is still u*v mod q
            prod.share0 <= mod_add3(r00_q, r01_q, rnd_s2);
            prod.share1 <= mod_add3(r10_q, r11_q, rnd_neg);
        end
    end

endmodule

//--- src/share_delay.sv
////////////////////////////////////////////////////////////////////////////
// zeroizable shift chain that delays a two-share coefficient
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module share_delay
    import pwm_pkg::*;
#(
    parameter int DEPTH = MULT_LATENCY
)
(
    input  logic          clk,
    input  logic          reset,
    input  logic          zeroize,
    input  masked_coeff_t din,
    output masked_coeff_t dout
);

    // entry 0 takes the input, entry DEPTH-1 is the delayed output
    masked_coeff_t chain [DEPTH];

    always_ff @(posedge clk) begin
        // clearing the whole chain keeps old shares from surfacing after a wipe
        if (reset || zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                chain[i] <= '0;
            end
        end else begin
            chain[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    assign dout = chain[DEPTH-1];

endmodule

//--- src/masked_mod_add.sv
////////////////////////////////////////////////////////////////////////////
// registered masked share adder mod q with product-only bypass
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module masked_mod_add
    import pwm_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               zeroize,
    input  masked_coeff_t      a,
    input  masked_coeff_t      b,
    input  logic [COEFF_W-1:0] rnd,
    input  logic               acc_sel,
    output masked_coeff_t      sum
);

    // the accumulate operand after mode gating
    masked_coeff_t b_gated;

    // the negated mask for share1, at most q
    logic [COEFF_W-1:0] rnd_neg;

    // next value of both output shares
    masked_coeff_t sum_d;

    always_comb begin
        // in product mode the addend is forced to zero but the mask is kept,
        // so the product shares are refreshed either way
        b_gated = acc_sel ? b : '0;
        rnd_neg = Q - rnd;

        // shares are only ever combined with their own index
        sum_d.share0 = mod_add3(a.share0, b_gated.share0, rnd);
        sum_d.share1 = mod_add3(a.share1, b_gated.share1, rnd_neg);
    end

    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            sum <= '0;
        end else begin
            sum <= sum_d;
        end
    end

endmodule

//--- src/pwm_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// valid and mode pipeline for items in flight through the masked datapath
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module pwm_ctrl
    import pwm_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic zeroize,
    input  logic in_valid,
    input  logic accumulate,
    output logic acc_sel,
    output logic out_valid
);

    // one bit per item in flight, oldest at the top
    logic [PWM_LATENCY-1:0] valid_pipe;

    // mode bit per item, short enough to meet the adder input
    logic [MULT_LATENCY-1:0] mode_pipe;

    // a mode bit only counts for a real item, idle slots carry product mode
    logic mode_in;

    assign mode_in = in_valid & accumulate;

    always_ff @(posedge clk) begin
        // a wipe drops every item in flight, so none of them reports a result
        if (reset || zeroize) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[PWM_LATENCY-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (reset || zeroize) begin
            mode_pipe <= '0;
        end else begin
            mode_pipe <= {mode_pipe[MULT_LATENCY-2:0], mode_in};
        end
    end

    // the mode bit leaves the pipe in the same cycle as the product and the
    // delayed w of its item, so each item picks its own adder path
    // even when product and accumulate items alternate
    assign acc_sel = mode_pipe[MULT_LATENCY-1];

    // the adder registers one cycle after the mode pipe ends
    assign out_valid = valid_pipe[PWM_LATENCY-1];

endmodule

//--- src/masked_pwm_top.sv
////////////////////////////////////////////////////////////////////////////
// masked pointwise multiply and multiply-accumulate unit, top level
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module masked_pwm_top
    import pwm_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          zeroize,
    input  logic          in_valid,
    input  logic          accumulate,
    input  masked_coeff_t u,
    input  masked_coeff_t v,
    input  masked_coeff_t w,
    input  pwm_rnd_t      rnd,
    output masked_coeff_t res,
    output logic          out_valid
);

    masked_coeff_t prod;
    masked_coeff_t w_dly;
    masked_coeff_t rnd_add_in;
    masked_coeff_t rnd_add_dly;
    logic          acc_sel;

    // the add mask travels in share0 of a spare delay line, share1 stays zero
    assign rnd_add_in = '{share0: rnd.rnd_add, share1: '0};

    pwm_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .zeroize    (zeroize),
        .in_valid   (in_valid),
        .accumulate (accumulate),
        .acc_sel    (acc_sel),
        .out_valid  (out_valid)
    );

    masked_mod_mult u_mult (
        .clk     (clk),
        .reset   (reset),
        .zeroize (zeroize),
        .u       (u),
        .v       (v),
        .rnd     (rnd.rnd_mult),
        .prod    (prod)
    );

    // w waits for the product of its own item
    share_delay #(.DEPTH(MULT_LATENCY)) u_w_dly (
        .clk     (clk),
        .reset   (reset),
        .zeroize (zeroize),
        .din     (w),
        .dout    (w_dly)
    );

    // rnd_add is sampled with in_valid and held here until the adder uses it
    share_delay #(.DEPTH(MULT_LATENCY)) u_rnd_dly (
        .clk     (clk),
        .reset   (reset),
        .zeroize (zeroize),
        .din     (rnd_add_in),
        .dout    (rnd_add_dly)
    );

    masked_mod_add u_add (
        .clk     (clk),
        .reset   (reset),
        .zeroize (zeroize),
        .a       (prod),
        .b       (w_dly),
        .rnd     (rnd_add_dly.share0),
        .acc_sel (acc_sel),
        .sum     (res)
    );

endmodule

//--- sim/masked_pwm_checker.sv
////////////////////////////////////////////////////////////////////////////
// concurrent assertions on reset, zeroize, valid timing and share range
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module masked_pwm_checker
    import pwm_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input logic          zeroize,
    input logic          in_valid,
    input logic          out_valid,
    input masked_coeff_t res
);

    // one bit per past cycle in which a wipe was sampled with the newest in bit 0
    logic [PWM_LATENCY-1:0] wipe_hist;

    // number of assertion failures seen so far
    int assert_fail_cnt = 0;

    always_ff @(posedge clk) begin
        wipe_hist <= {wipe_hist[PWM_LATENCY-2:0], reset | zeroize};
    end

    // the valid pipe is empty right after a reset edge
    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            assert_fail_cnt++;
        end

    // an item sampled with the wipe is lost too, so the whole latency stays quiet
    zeroize_flushes_valid: assert property (
        @(posedge clk) zeroize |=> (!out_valid) [*PWM_LATENCY])
        else begin
            $error("out_valid high within the latency window after zeroize");
            assert_fail_cnt++;
        end

    // without a wipe in the window each in_valid shows up exactly once
    valid_latency: assert property (
        @(posedge clk) (wipe_hist == '0) |-> (out_valid == $past(in_valid, PWM_LATENCY)))
        else begin
            $error("out_valid does not follow in_valid by the pipeline latency");
            assert_fail_cnt++;
        end

    // both result shares stay reduced
    shares_reduced: assert property (
        @(posedge clk) out_valid |-> ((res.share0 < Q) && (res.share1 < Q)))
        else begin
            $error("result share not below the modulus");
            assert_fail_cnt++;
        end

endmodule

bind masked_pwm_top masked_pwm_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .zeroize   (zeroize),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .res       (res)
);

//--- sim/masked_pwm_tb.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the masked pointwise multiply unit with a
// reference model, result monitor, timeout and summary
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module masked_pwm_tb
    import pwm_pkg::*;
();

    localparam int N_PWM = 12;
    localparam int N_PWMA = 6;
    localparam int N_STREAM = 64;
    localparam int N_ZERO = 4;
    localparam int N_TESTS = 5;
    localparam int ITEMS = N_PWM + N_PWMA + N_STREAM + N_ZERO;
    localparam int TIMEOUT_CYCLES = 2 * (ITEMS + 4 * PWM_LATENCY * N_TESTS) + 100;

    logic          clk;
    logic          reset;
    logic          zeroize;
    logic          in_valid;
    logic          accumulate;
    masked_coeff_t u;
    masked_coeff_t v;
    masked_coeff_t w;
    pwm_rnd_t      rnd;
    masked_coeff_t res;
    logic          out_valid;

    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int unsigned issued_cnt = 0;
    int unsigned seen_cnt = 0;
    int unsigned out_count = 0;
    int unsigned cycle_cnt = 0;

    // expected unmasked results and sampling cycles of the items in flight in issue order
    int unsigned exp_q [$];
    int unsigned issue_q [$];

    masked_pwm_top dut (
        .clk        (clk),
        .reset      (reset),
        .zeroize    (zeroize),
        .in_valid   (in_valid),
        .accumulate (accumulate),
        .u          (u),
        .v          (v),
        .w          (w),
        .rnd        (rnd),
        .res        (res),
        .out_valid  (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned rand_below_q();
        return $urandom % Q;
    endfunction

    // share0 is random, share1 makes the pair sum to x mod q
    function automatic masked_coeff_t split_value(input int unsigned x);
        masked_coeff_t c;
        int unsigned   s0;
        s0 = rand_below_q();
        c.share0 = s0[COEFF_W-1:0];
        c.share1 = COEFF_W'((x + Q - s0) % Q);
        return c;
    endfunction

    function automatic int unsigned unmask(input masked_coeff_t c);
        return (32'(c.share0) + 32'(c.share1)) % Q;
    endfunction

    // u*v mod q, plus w in accumulate mode, on the unmasked operands
    function automatic int unsigned reference_result(input masked_coeff_t uc,
                                                     input masked_coeff_t vc,
                                                     input masked_coeff_t wc,
                                                     input logic acc);
        longint unsigned p;
        p = (64'(unmask(uc)) * 64'(unmask(vc))) % Q;
        if (acc) begin
            p = (p + unmask(wc)) % Q;
        end
        return 32'(p);
    endfunction

    task automatic compare(input string name, input longint unsigned actual,
                           input longint unsigned expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            err_cnt++;
        end
    endtask

    // mismatches found here plus assertion failures in the bound checker
    function automatic int error_total();
        return err_cnt + dut.u_checker.assert_fail_cnt;
    endfunction

    task automatic finish_test(input string name, input int errors_before);
        if (error_total() == errors_before) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, error_total() - errors_before);
        end
    endtask

    // drives one item for one cycle with fresh shares and fresh masks
    task automatic issue_item(input int unsigned uval, input int unsigned vval,
                              input int unsigned wval, input logic acc);
        @(posedge clk);
        u <= split_value(uval);
        v <= split_value(vval);
        w <= split_value(wval);
        rnd <= '{rnd_mult: COEFF_W'(rand_below_q()), rnd_add: COEFF_W'(rand_below_q())};
        accumulate <= acc;
        in_valid <= 1'b1;
        issued_cnt++;
    endtask

    task automatic end_issue();
        @(posedge clk);
        in_valid <= 1'b0;
        accumulate <= 1'b0;
    endtask

    // the monitor counts results on the rising edge, so this polls on the falling one
    task automatic wait_results();
        while (seen_cnt != issued_cnt) begin
            @(negedge clk);
        end
    endtask

    task automatic reset_state();
        int errors_before;
        errors_before = error_total();
        repeat (10) begin
            @(negedge clk);
            compare("out_valid", out_valid, 0);
        end
        finish_test("reset_state", errors_before);
    endtask

    task automatic pwm_single();
        int unsigned edge_val [3];
        int unsigned a;
        int unsigned b;
        int          errors_before;
        edge_val[0] = 0;
        edge_val[1] = 1;
        edge_val[2] = Q - 1;
        errors_before = error_total();
        // the first nine items walk every pair of edge operands
        for (int i = 0; i < N_PWM; i++) begin
            if (i < 9) begin
                a = edge_val[i % 3];
                b = edge_val[i / 3];
            end else begin
                a = rand_below_q();
                b = rand_below_q();
            end
            issue_item(a, b, rand_below_q(), 1'b0);
            end_issue();
            wait_results();
        end
        finish_test("pwm_single", errors_before);
    endtask

    task automatic pwma_single();
        int errors_before;
        errors_before = error_total();
        issue_item(Q - 1, Q - 1, Q - 1, 1'b1);
        end_issue();
        wait_results();
        issue_item(0, 0, Q - 1, 1'b1);
        end_issue();
        wait_results();
        issue_item(1, 1, Q - 1, 1'b1);
        end_issue();
        wait_results();
        for (int i = 3; i < N_PWMA; i++) begin
            issue_item(rand_below_q(), rand_below_q(), rand_below_q(), 1'b1);
            end_issue();
            wait_results();
        end
        finish_test("pwma_single", errors_before);
    endtask

    task automatic streaming_mixed();
        int          errors_before;
        int unsigned count_before;
        errors_before = error_total();
        count_before = out_count;
        for (int i = 0; i < N_STREAM; i++) begin
            issue_item(rand_below_q(), rand_below_q(), rand_below_q(), $urandom % 2);
        end
        end_issue();
        wait_results();
        compare("out_valid count", out_count - count_before, N_STREAM);
        finish_test("streaming_mixed", errors_before);
    endtask

    task automatic zeroize_flush();
        int          errors_before;
        int unsigned count_before;
        errors_before = error_total();
        for (int i = 0; i < N_ZERO - 1; i++) begin
            issue_item(rand_below_q(), rand_below_q(), rand_below_q(), $urandom % 2);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        accumulate <= 1'b0;
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        // the wiped items never report, so they leave the issue count
        issued_cnt = issued_cnt - (N_ZERO - 1);
        @(negedge clk);
        count_before = out_count;
        repeat (2 * PWM_LATENCY) @(negedge clk);
        compare("out_valid count after zeroize", out_count - count_before, 0);
        issue_item(rand_below_q(), rand_below_q(), rand_below_q(), 1'b1);
        end_issue();
        wait_results();
        compare("out_valid count", out_count - count_before, 1);
        finish_test("zeroize_flush", errors_before);
    endtask

    // outputs are read before this edge updates them, inputs as the DUT samples them
    always @(posedge clk) begin : monitor
        int unsigned expected;
        int unsigned issued_at;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            if (out_valid) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    $display("error: out_valid was raised with no item in flight");
                    err_cnt++;
                end else begin
                    expected = exp_q.pop_front();
                    issued_at = issue_q.pop_front();
                    compare("res", unmask(res), expected);
                    compare("out_valid latency", cycle_cnt - issued_at, PWM_LATENCY);
                    compare("res.share0 below q", res.share0 < Q, 1);
                    compare("res.share1 below q", res.share1 < Q, 1);
                    seen_cnt++;
                end
            end
            // a wipe drops everything in flight, including an item sampled with it
            if (reset || zeroize) begin
                exp_q.delete();
                issue_q.delete();
            end else if (in_valid) begin
                exp_q.push_back(reference_result(u, v, w, accumulate));
                issue_q.push_back(cycle_cnt);
            end
        end
    end

    initial begin : main
        void'($urandom(36));
        reset = 1'b1;
        zeroize = 1'b0;
        in_valid = 1'b0;
        accumulate = 1'b0;
        u = '0;
        v = '0;
        w = '0;
        rnd = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        reset_state();
        pwm_single();
        pwma_single();
        streaming_mixed();
        zeroize_flush();
        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 pass_cnt, fail_cnt, error_total());
        if (fail_cnt == 0 && error_total() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
src/pwm_pkg.sv
src/masked_mod_mult.sv
src/share_delay.sv
src/masked_mod_add.sv
src/pwm_ctrl.sv
src/masked_pwm_top.sv
sim/masked_pwm_checker.sv
sim/masked_pwm_tb.sv
